/* run_sim.sh */
#!/bin/sh
# Build and run the load queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module load_queue_tb -o load_queue_sim \
	&& ./obj_dir/load_queue_sim \
	|| exit 1

/* sim.f */
source/lq_pkg.sv
source/lq_entry.sv
source/lq_pointers.sv
source/lq_mem_issue.sv
source/lq_retire.sv
source/load_queue.sv
test/load_queue_tb.sv

/* source/load_queue.sv */
`timescale 1ns/1ps

module load_queue import lq_pkg::*; #(
	parameter int lq_depth = 8
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        lq_clean,

	input  logic                        mem_in1,
	input  logic [xlen-1:0]             pc1,
	input  logic [inst_width-1:0]       inst1,
	input  logic [xlen-1:0]             opa1,
	input  logic [xlen-1:0]             opb1,
	input  logic                        opb_valid1,
	input  logic [rob_idx_width-1:0]    rob_idx1,
	input  logic [prf_tag_width-1:0]    dest_idx1,

	input  logic                        mem_in2,
	input  logic [xlen-1:0]             pc2,
	input  logic [inst_width-1:0]       inst2,
	input  logic [xlen-1:0]             opa2,
	input  logic [xlen-1:0]             opb2,
	input  logic                        opb_valid2,
	input  logic [rob_idx_width-1:0]    rob_idx2,
	input  logic [prf_tag_width-1:0]    dest_idx2,

	input  logic [xlen-1:0]             cdb1_data,
	input  logic [prf_tag_width-1:0]    cdb1_tag,
	input  logic                        cdb1_valid,
	input  logic [xlen-1:0]             cdb2_data,
	input  logic [prf_tag_width-1:0]    cdb2_tag,
	input  logic                        cdb2_valid,

	input  logic                        mem_resp_valid,
	input  logic [$clog2(lq_depth)-1:0] mem_resp_id,
	input  logic [xlen-1:0]             mem_resp_data,

	output logic                        lq_full,
	output logic                        mem_req_valid,
	output logic [xlen-1:0]             mem_req_addr,
	output logic [$clog2(lq_depth)-1:0] mem_req_id,

	output logic                        wb_valid,
	output logic [xlen-1:0]             wb_data,
	output logic [prf_tag_width-1:0]    wb_dest_tag,
	output logic [rob_idx_width-1:0]    wb_rob_idx,
	output logic [xlen-1:0]             wb_pc
);

	localparam int idx_width = $clog2(lq_depth);

	logic [idx_width-1:0]     head;
	logic                     retire;
	logic [lq_depth-1:0]      load_enable1;
	logic [lq_depth-1:0]      load_enable2;
	logic [lq_depth-1:0]      free_enable;
	logic [lq_depth-1:0]      request;
	logic [lq_depth-1:0]      in_use;
	logic [lq_depth-1:0]      ready;
	logic [lq_depth-1:0]      addr_valid;
	logic [lq_depth-1:0]      requested;
	logic [xlen-1:0]          entry_pc [lq_depth];
	logic [inst_width-1:0]    entry_inst [lq_depth];
	logic [xlen-1:0]          entry_opa [lq_depth];
	logic [xlen-1:0]          entry_opb [lq_depth];
	logic [rob_idx_width-1:0] entry_rob_idx [lq_depth];
	logic [prf_tag_width-1:0] entry_dest_tag [lq_depth];
	logic [xlen-1:0]          entry_mem_value [lq_depth];

	for (genvar i = 0; i < lq_depth; i++) begin : g_entry
		assign free_enable[i] = retire && (head == idx_width'(i));  // Only the head retires

		lq_entry i_lq_entry (
			.clock(clock), .reset(reset), .clean(lq_clean),
			.load_enable1(load_enable1[i]), .load_enable2(load_enable2[i]),
			.free_enable(free_enable[i]), .request(request[i]),
			.pc1(pc1), .inst1(inst1), .opa1(opa1), .opb1(opb1), .opb_valid1(opb_valid1),
			.rob_idx1(rob_idx1), .dest_idx1(dest_idx1),
			.pc2(pc2), .inst2(inst2), .opa2(opa2), .opb2(opb2), .opb_valid2(opb_valid2),
			.rob_idx2(rob_idx2), .dest_idx2(dest_idx2),
			.cdb1_data(cdb1_data), .cdb1_tag(cdb1_tag), .cdb1_valid(cdb1_valid),
			.cdb2_data(cdb2_data), .cdb2_tag(cdb2_tag), .cdb2_valid(cdb2_valid),
			.mem_data(mem_resp_data),
			.mem_data_valid(mem_resp_valid && (mem_resp_id == idx_width'(i))),
			.in_use(in_use[i]), .ready(ready[i]),
			.pc(entry_pc[i]), .inst(entry_inst[i]),
			.opa(entry_opa[i]), .opb(entry_opb[i]), .addr_valid(addr_valid[i]),
			.rob_idx(entry_rob_idx[i]), .dest_tag(entry_dest_tag[i]),
			.mem_value(entry_mem_value[i]), .requested(requested[i])
		);
	end

	lq_pointers #(.lq_depth(lq_depth)) i_lq_pointers (
		.clock(clock), .reset(reset), .clean(lq_clean),
		.mem_in1(mem_in1), .mem_in2(mem_in2), .retire(retire),
		.head(head), .load_enable1(load_enable1), .load_enable2(load_enable2),
		.full(lq_full)
	);

	lq_mem_issue #(.lq_depth(lq_depth)) i_lq_mem_issue (
		.head(head), .in_use(in_use), .addr_valid(addr_valid), .requested(requested),
		.opa(entry_opa), .opb(entry_opb),
		.request(request), .mem_req_valid(mem_req_valid),
		.mem_req_addr(mem_req_addr), .mem_req_id(mem_req_id)
	);

	lq_retire #(.lq_depth(lq_depth)) i_lq_retire (
		.head(head), .ready(ready), .inst(entry_inst), .mem_value(entry_mem_value),
		.dest_tag(entry_dest_tag), .rob_idx(entry_rob_idx), .pc(entry_pc),
		.retire(retire), .wb_valid(wb_valid), .wb_data(wb_data),
		.wb_dest_tag(wb_dest_tag), .wb_rob_idx(wb_rob_idx), .wb_pc(wb_pc)
	);

endmodule

/* source/lq_entry.sv */
`timescale 1ns/1ps

module lq_entry import lq_pkg::*; (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     clean,
	input  logic                     load_enable1,
	input  logic                     load_enable2,
	input  logic                     free_enable,
	input  logic                     request,

	input  logic [xlen-1:0]          pc1,
	input  logic [inst_width-1:0]    inst1,
	input  logic [xlen-1:0]          opa1,
	input  logic [xlen-1:0]          opb1,        // Data, or a tag in the low bits
	input  logic                     opb_valid1,
	input  logic [rob_idx_width-1:0] rob_idx1,
	input  logic [prf_tag_width-1:0] dest_idx1,

	input  logic [xlen-1:0]          pc2,
	input  logic [inst_width-1:0]    inst2,
	input  logic [xlen-1:0]          opa2,
	input  logic [xlen-1:0]          opb2,
	input  logic                     opb_valid2,
	input  logic [rob_idx_width-1:0] rob_idx2,
	input  logic [prf_tag_width-1:0] dest_idx2,

	input  logic [xlen-1:0]          cdb1_data,
	input  logic [prf_tag_width-1:0] cdb1_tag,
	input  logic                     cdb1_valid,
	input  logic [xlen-1:0]          cdb2_data,
	input  logic [prf_tag_width-1:0] cdb2_tag,
	input  logic                     cdb2_valid,

	input  logic [xlen-1:0]          mem_data,
	input  logic                     mem_data_valid,

	output logic                     in_use,
	output logic                     ready,
	output logic [xlen-1:0]          pc,
	output logic [inst_width-1:0]    inst,
	output logic [xlen-1:0]          opa,
	output logic [xlen-1:0]          opb,
	output logic                     addr_valid,
	output logic [rob_idx_width-1:0] rob_idx,
	output logic [prf_tag_width-1:0] dest_tag,
	output logic [xlen-1:0]          mem_value,
	output logic                     requested
);

	logic load;
	logic waiting;
	logic hit1;
	logic hit2;
	logic capture;
	logic value_valid;

	assign load = load_enable1 | load_enable2;
	assign waiting = in_use & ~addr_valid;  // Offset still a tag
	assign hit1 = waiting & cdb1_valid & (opb[prf_tag_width-1:0] == cdb1_tag);
	assign hit2 = waiting & cdb2_valid & (opb[prf_tag_width-1:0] == cdb2_tag);

	// Only a requested, live load takes a response, so late data after a flush is dropped
	assign capture = in_use & requested & ~value_valid & mem_data_valid;
	assign ready = in_use & addr_valid & value_valid;

	always_ff @(posedge clock) begin
		if (reset) begin
			in_use      <= 1'b0;
			addr_valid  <= 1'b0;
			value_valid <= 1'b0;
			requested   <= 1'b0;
		end else if (clean) begin
			in_use <= 1'b0;
		end else if (load) begin
			in_use      <= 1'b1;  // Wins over a free in the same cycle
			addr_valid  <= load_enable1 ? opb_valid1 : opb_valid2;
			value_valid <= 1'b0;
			requested   <= 1'b0;
		end else begin
			if (free_enable) begin
				in_use <= 1'b0;
			end
			if (hit1 | hit2) begin
				addr_valid <= 1'b1;
			end
			if (capture) begin
				value_valid <= 1'b1;
			end
			if (request) begin
				requested <= 1'b1;  // Held until the slot is reloaded
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			if (load_enable1) begin
				pc       <= pc1;
				inst     <= inst1;
				opa      <= opa1;
				opb      <= opb1;
				rob_idx  <= rob_idx1;
				dest_tag <= dest_idx1;
			end else begin
				pc       <= pc2;
				inst     <= inst2;
				opa      <= opa2;
				opb      <= opb2;
				rob_idx  <= rob_idx2;
				dest_tag <= dest_idx2;
			end
		end else begin
			if (hit2) begin
				opb <= cdb2_data;  // Cdb2 wins when both match
			end else if (hit1) begin
				opb <= cdb1_data;
			end
			if (capture) begin
				mem_value <= mem_data;
			end
		end
	end

endmodule

/* source/lq_mem_issue.sv */
`timescale 1ns/1ps

module lq_mem_issue import lq_pkg::*; #(
	parameter int lq_depth = 8
) (
	input  logic [$clog2(lq_depth)-1:0] head,
	input  logic [lq_depth-1:0]         in_use,
	input  logic [lq_depth-1:0]         addr_valid,
	input  logic [lq_depth-1:0]         requested,
	input  logic [xlen-1:0]             opa [lq_depth],
	input  logic [xlen-1:0]             opb [lq_depth],
	output logic [lq_depth-1:0]         request,
	output logic                        mem_req_valid,
	output logic [xlen-1:0]             mem_req_addr,
	output logic [$clog2(lq_depth)-1:0] mem_req_id
);

	localparam int idx_width = $clog2(lq_depth);

	logic [lq_depth-1:0]  eligible;
	logic [idx_width-1:0] slot;
	logic [idx_width-1:0] pick;
	logic                 found;

	assign eligible = in_use & addr_valid & ~requested;

	// Age order scan, the head is the oldest
	always_comb begin
		found = 1'b0;
		pick = head;
		slot = head;
		for (int k = 0; k < lq_depth; k++) begin
			slot = head + idx_width'(k);
			if (!found && eligible[slot]) begin
				found = 1'b1;
				pick = slot;
			end
		end
	end

	always_comb begin
		request = '0;
		if (found) begin
			request[pick] = 1'b1;  // Entry latches its requested flag at the edge
		end
	end

	assign mem_req_valid = found;
	assign mem_req_id = pick;
	assign mem_req_addr = opa[pick] + opb[pick];  // Base plus offset, alignment unchecked

endmodule

/* source/lq_pkg.sv */
package lq_pkg;

	localparam int xlen = 64;          // Data and address width
	localparam int inst_width = 32;
	localparam int rob_idx_width = 6;  // One bit over the 32-entry ROB index for wrap
	localparam int prf_tag_width = 6;  // 64 physical registers

	// Encodings follow funct3 of the RISC-V load instructions
	typedef enum logic [2:0] {
		load_byte   = 3'b000,
		load_half   = 3'b001,
		load_word   = 3'b010,
		load_double = 3'b011,
		load_byte_u = 3'b100,
		load_half_u = 3'b101,
		load_word_u = 3'b110
	} load_size_t;

	function automatic load_size_t decode_load_size(input logic [inst_width-1:0] inst);
		load_size_t size;
		case (inst[14:12])
			3'b000:  size = load_byte;
			3'b001:  size = load_half;
			3'b010:  size = load_word;
			3'b011:  size = load_double;
			3'b100:  size = load_byte_u;
			3'b101:  size = load_half_u;
			3'b110:  size = load_word_u;
			default: size = load_double;  // 3'b111 is no load, taken as full width
		endcase
		return size;
	endfunction

endpackage

/* source/lq_pointers.sv */
`timescale 1ns/1ps

module lq_pointers #(
	parameter int lq_depth = 8
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        clean,
	input  logic                        mem_in1,
	input  logic                        mem_in2,
	input  logic                        retire,
	output logic [$clog2(lq_depth)-1:0] head,
	output logic [lq_depth-1:0]         load_enable1,
	output logic [lq_depth-1:0]         load_enable2,
	output logic                        full
);

	localparam int idx_width = $clog2(lq_depth);
	localparam int count_width = idx_width + 1;  // Must hold lq_depth itself

	logic [idx_width-1:0]   tail;
	logic [idx_width-1:0]   tail_plus1;
	logic [count_width-1:0] count;
	logic [count_width-1:0] accepted;
	logic [count_width-1:0] retired;

	assign tail_plus1 = tail + 1'b1;  // Wraps, depth is a power of two
	assign accepted = count_width'(mem_in1) + count_width'(mem_in2);
	assign retired = count_width'(retire);

	// Fewer than two free slots left
	assign full = count >= count_width'(lq_depth - 1);

	always_comb begin
		load_enable1 = '0;
		load_enable2 = '0;
		if (mem_in1) begin
			load_enable1[tail] = 1'b1;
		end
		if (mem_in2) begin
			if (mem_in1) begin
				load_enable2[tail_plus1] = 1'b1;
			end else begin
				load_enable2[tail] = 1'b1;  // Slot 2 alone takes the tail
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset || clean) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			head  <= head + idx_width'(retire);
			tail  <= tail + idx_width'(accepted);
			count <= count + accepted - retired;
		end
	end

endmodule

/* source/lq_retire.sv */
`timescale 1ns/1ps

module lq_retire import lq_pkg::*; #(
	parameter int lq_depth = 8
) (
	input  logic [$clog2(lq_depth)-1:0] head,
	input  logic [lq_depth-1:0]         ready,
	input  logic [inst_width-1:0]       inst [lq_depth],
	input  logic [xlen-1:0]             mem_value [lq_depth],
	input  logic [prf_tag_width-1:0]    dest_tag [lq_depth],
	input  logic [rob_idx_width-1:0]    rob_idx [lq_depth],
	input  logic [xlen-1:0]             pc [lq_depth],
	output logic                        retire,
	output logic                        wb_valid,
	output logic [xlen-1:0]             wb_data,
	output logic [prf_tag_width-1:0]    wb_dest_tag,
	output logic [rob_idx_width-1:0]    wb_rob_idx,
	output logic [xlen-1:0]             wb_pc
);

	load_size_t      size;
	logic [xlen-1:0] value;

	assign size = decode_load_size(inst[head]);
	assign value = mem_value[head];

	assign retire = ready[head];  // Frees the head at this edge
	assign wb_valid = ready[head];
	assign wb_dest_tag = dest_tag[head];
	assign wb_rob_idx = rob_idx[head];
	assign wb_pc = pc[head];

	always_comb begin
		case (size)
			load_byte:   wb_data = {{(xlen-8){value[7]}}, value[7:0]};
			load_half:   wb_data = {{(xlen-16){value[15]}}, value[15:0]};
			load_word:   wb_data = {{(xlen-32){value[31]}}, value[31:0]};
			load_byte_u: wb_data = {{(xlen-8){1'b0}}, value[7:0]};
			load_half_u: wb_data = {{(xlen-16){1'b0}}, value[15:0]};
			load_word_u: wb_data = {{(xlen-32){1'b0}}, value[31:0]};
			default:     wb_data = value;  // Double needs no extension
		endcase
	end

endmodule

/* test/load_queue_tb.sv */
`timescale 1ns/1ps

module load_queue_tb;
	import lq_pkg::*;

	localparam int lq_depth = 8;
	localparam int idx_width = $clog2(lq_depth);
	localparam logic [xlen-1:0] mem_pattern = 64'h0123456789abcdef;
	localparam string tests_path = "test/load_queue_tests.txt";

	logic clock;
	logic reset;
	logic lq_clean;
	logic mem_in1, mem_in2;
	logic [xlen-1:0] pc1, pc2, opa1, opa2, opb1, opb2;
	logic [inst_width-1:0] inst1, inst2;
	logic opb_valid1, opb_valid2;
	logic [rob_idx_width-1:0] rob_idx1, rob_idx2;
	logic [prf_tag_width-1:0] dest_idx1, dest_idx2;
	logic [xlen-1:0] cdb1_data, cdb2_data;
	logic [prf_tag_width-1:0] cdb1_tag, cdb2_tag;
	logic cdb1_valid, cdb2_valid;
	logic mem_resp_valid;
	logic [idx_width-1:0] mem_resp_id;
	logic [xlen-1:0] mem_resp_data;
	logic lq_full;
	logic mem_req_valid;
	logic [xlen-1:0] mem_req_addr;
	logic [idx_width-1:0] mem_req_id;
	logic wb_valid;
	logic [xlen-1:0] wb_data;
	logic [prf_tag_width-1:0] wb_dest_tag;
	logic [rob_idx_width-1:0] wb_rob_idx;
	logic [xlen-1:0] wb_pc;

	// Expected writebacks in dispatch order
	logic [prf_tag_width-1:0] exp_dest [$];
	logic [rob_idx_width-1:0] exp_rob [$];
	load_size_t exp_size [$];
	logic [xlen-1:0] exp_addr [$];
	logic [xlen-1:0] exp_pc [$];

	// Outstanding memory reads
	logic [idx_width-1:0] pend_id [$];
	logic [xlen-1:0] pend_addr [$];
	int pend_delay [$];

	int cycles;
	int limit;
	int held;  // Loads the queue should be holding
	bit saw_full;
	logic [63:0] f [16];

	load_queue #(.lq_depth(lq_depth)) i_load_queue (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic stop_with_error(input string text);
		$display("%s", text);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [xlen-1:0] got,
			input logic [xlen-1:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_tag(input string name, input logic [prf_tag_width-1:0] got,
			input logic [prf_tag_width-1:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_rob(input string name, input logic [rob_idx_width-1:0] got,
			input logic [rob_idx_width-1:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_size(input string name, input load_size_t got, input load_size_t exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("** Error %s: got %h expected %h", name, got, exp));
	endtask

	// Low bytes of the word, sign or zero extended as the load size says
	function automatic logic [xlen-1:0] extend_loaded(input logic [xlen-1:0] v,
			input load_size_t size);
		logic [xlen-1:0] r;
		case (size)
			load_byte:   r = {{56{v[7]}}, v[7:0]};
			load_half:   r = {{48{v[15]}}, v[15:0]};
			load_word:   r = {{32{v[31]}}, v[31:0]};
			load_byte_u: r = {56'd0, v[7:0]};
			load_half_u: r = {48'd0, v[15:0]};
			load_word_u: r = {32'd0, v[31:0]};
			default:     r = v;
		endcase
		return r;
	endfunction

	task automatic end_strobes();
		mem_in1 <= 1'b0;
		mem_in2 <= 1'b0;
		cdb1_valid <= 1'b0;
		cdb2_valid <= 1'b0;
		lq_clean <= 1'b0;
	endtask

	// Memory model, random latency so answers come back out of order
	always @(posedge clock) begin : mem_model
		int pick;
		bit sent;
		if (reset) begin
			mem_resp_valid <= 1'b0;
		end else begin
			mem_resp_valid <= 1'b0;
			sent = 1'b0;
			pick = 0;
			for (int i = 0; i < pend_delay.size(); i++) begin
				if (pend_delay[i] > 0)
					pend_delay[i]--;
				if (!sent && pend_delay[i] == 0) begin
					sent = 1'b1;
					pick = i;
				end
			end
			if (sent) begin
				mem_resp_valid <= 1'b1;
				mem_resp_id <= pend_id[pick];
				mem_resp_data <= pend_addr[pick] ^ mem_pattern;
				pend_id.delete(pick);
				pend_addr.delete(pick);
				pend_delay.delete(pick);
			end
			if (mem_req_valid) begin
				pend_id.push_back(mem_req_id);
				pend_addr.push_back(mem_req_addr);
				pend_delay.push_back(1 + int'($urandom % 6));
			end
		end
	end

	// Writeback monitor and timeout
	always @(posedge clock) begin
		if (!reset) begin
			cycles++;
			if (cycles > limit)
				stop_with_error($sformatf("Timeout after %0d cycles", cycles));
			if (lq_full)
				saw_full = 1'b1;
			check_flag("lq_full", lq_full, held >= lq_depth - 1);  // Fewer than two free
			if (wb_valid) begin
				if (exp_dest.size() == 0) begin
					stop_with_error("Writeback seen while no load was expected to retire");
				end else begin
					check_data("wb_data", wb_data,
						extend_loaded(exp_addr[0] ^ mem_pattern, exp_size[0]));
					check_tag("wb_dest_tag", wb_dest_tag, exp_dest[0]);
					check_rob("wb_rob_idx", wb_rob_idx, exp_rob[0]);
					check_data("wb_pc", wb_pc, exp_pc[0]);
					check_size("size", i_load_queue.i_lq_retire.size, exp_size[0]);
					void'(exp_dest.pop_front());
					void'(exp_rob.pop_front());
					void'(exp_size.pop_front());
					void'(exp_addr.pop_front());
					void'(exp_pc.pop_front());
				end
			end
			if (lq_clean)
				held = 0;
			else
				held = held + int'(mem_in1) + int'(mem_in2) - int'(wb_valid);
		end
	end

	initial begin
		int fd;
		int n;
		int records;
		int size_field;
		string line;
		byte kind;
		void'($urandom(32'h5db80436));
		reset = 1'b1;
		lq_clean = 1'b0;
		{mem_in1, mem_in2, opb_valid1, opb_valid2} = '0;
		{pc1, pc2, opa1, opa2, opb1, opb2, inst1, inst2} = '0;
		{rob_idx1, rob_idx2, dest_idx1, dest_idx2} = '0;
		{cdb1_data, cdb2_data, cdb1_tag, cdb2_tag, cdb1_valid, cdb2_valid} = '0;
		{mem_resp_valid, mem_resp_id, mem_resp_data} = '0;
		cycles = 0;
		held = 0;
		saw_full = 1'b0;
		records = 0;
		limit = 1000;
		fd = $fopen(tests_path, "r");
		if (fd == 0)
			stop_with_error("Cannot open the test data file");
		while ($fgets(line, fd) != 0)
			if (line.len() > 1 && line.getc(0) != "#")
				records++;
		$fclose(fd);
		limit = 40 * records;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		fd = $fopen(tests_path, "r");
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				kind = line.getc(0);
				case (kind)
					"E": begin
						n = $sscanf(line, "E %h %h %h %h %h", f[0], f[1], size_field, f[2], f[3]);
						exp_dest.push_back(f[0][prf_tag_width-1:0]);
						exp_rob.push_back(f[1][rob_idx_width-1:0]);
						exp_size.push_back(load_size_t'(size_field[2:0]));
						exp_addr.push_back(f[2]);
						exp_pc.push_back(f[3]);
					end
					"D": begin
						n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
							f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
							f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
						if (n != 16)
							stop_with_error("Malformed dispatch record in the test data file");
						@(negedge clock);
						while (lq_full)
							@(negedge clock);  // Hold dispatch back while full
						@(posedge clock);
						mem_in1 <= f[0][0];
						pc1 <= f[1];
						inst1 <= f[2][inst_width-1:0];
						opa1 <= f[3];
						opb1 <= f[4];
						opb_valid1 <= f[5][0];
						rob_idx1 <= f[6][rob_idx_width-1:0];
						dest_idx1 <= f[7][prf_tag_width-1:0];
						mem_in2 <= f[8][0];
						pc2 <= f[9];
						inst2 <= f[10][inst_width-1:0];
						opa2 <= f[11];
						opb2 <= f[12];
						opb_valid2 <= f[13][0];
						rob_idx2 <= f[14][rob_idx_width-1:0];
						dest_idx2 <= f[15][prf_tag_width-1:0];
						@(posedge clock);
						end_strobes();
					end
					"B": begin
						n = $sscanf(line, "B %h %h %h", f[0], f[1], f[2]);
						@(posedge clock);
						if (f[0] == 64'd1) begin
							cdb1_valid <= 1'b1;
							cdb1_tag <= f[1][prf_tag_width-1:0];
							cdb1_data <= f[2];
						end else begin
							cdb2_valid <= 1'b1;
							cdb2_tag <= f[1][prf_tag_width-1:0];
							cdb2_data <= f[2];
						end
						@(posedge clock);
						end_strobes();
					end
					"C": begin
						@(posedge clock);
						lq_clean <= 1'b1;
						@(posedge clock);
						end_strobes();
					end
					"I": begin
						n = $sscanf(line, "I %d", size_field);
						repeat (size_field) @(posedge clock);
					end
					"Q": begin
						while (exp_dest.size() != 0)
							@(posedge clock);
					end
					default: stop_with_error("Unknown record kind in the test data file");
				endcase
			end
		end
		$fclose(fd);
		while (exp_dest.size() != 0)
			@(posedge clock);
		repeat (10) @(posedge clock);  // Catch any stray writeback
		if (!saw_full) begin
			stop_with_error("lq_full never rose while the queue was filled");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* test/load_queue_tests.txt */
# E dest rob size addr pc : expected writeback, pushed in dispatch order
# D v pc inst opa opb opb_valid rob dest (slot 1, then slot 2); B bus tag data; C; I n; Q
E 10 00 0 8010 1000
E 11 01 1 8028 1004
D 1 1000 00000003 8000 10 1 00 10 1 1004 00001003 8000 28 1 01 11
E 12 02 2 9004 1008
E 13 03 3 9100 100c
D 1 1008 00002003 9000 4 1 02 12 1 100c 00003003 9000 100 1 03 13
E 14 04 4 a007 1010
E 15 05 5 a032 1014
D 1 1010 00004003 a000 7 1 04 14 1 1014 00005003 a000 32 1 05 15
E 16 06 6 b040 1018
D 0 0 0 0 0 0 0 0 1 1018 00006003 b000 40 1 06 16
Q
E 20 08 3 c200 2000
E 21 09 2 c210 2004
D 1 2000 00003003 c000 21 0 08 20 1 2004 00002003 c010 21 0 09 21
E 22 0a 0 c220 2008
E 23 0b 4 c230 200c
D 1 2008 00000003 c020 21 0 0a 22 1 200c 00004003 c030 21 0 0b 23
E 24 0c 1 c340 2010
E 25 0d 5 c350 2014
D 1 2010 00001003 c040 22 0 0c 24 1 2014 00005003 c050 22 0 0d 25
E 26 0e 6 c360 2018
E 27 0f 3 c370 201c
D 1 2018 00006003 c060 22 0 0e 26 1 201c 00003003 c070 22 0 0f 27
B 1 21 200
B 2 22 300
E 28 10 2 d008 2020
E 29 11 0 d009 2024
D 1 2020 00002003 d000 8 1 10 28 1 2024 00000003 d000 9 1 11 29
Q
D 1 3000 00003003 e000 30 0 12 30 1 3004 00003003 e100 8 1 13 31
C
I 8
E 32 14 3 f010 3008
D 1 3008 00003003 f000 10 1 14 32 0 0 0 0 0 0 0 0
Q
